// File: hw/emesh_pkg.sv
//------------------
// Shared FIFO sizes, emesh packet layout
// and the datamode encoding
//------------------
package emesh_pkg;

   // FIFO geometry
   localparam int FIFO_DEPTH = 32;
   localparam int ADDR_W     = 5;
   // Extra wrap bit separates full from empty
   localparam int PTR_W      = ADDR_W + 1;

   // Write-side fill level that raises prog_full
   localparam int PROG_FULL_LEVEL = 24;

   // Packed packet word, no padding bits
   localparam int PKT_W = 103;

   // Field offsets, bit 0 upward
   // write
   localparam int WRITE_POS    = 0;
   // datamode, 2 bits
   localparam int DATAMODE_LSB = 1;
   // ctrlmode, 4 bits
   localparam int CTRLMODE_LSB = 3;
   // dstaddr, 32 bits
   localparam int DSTADDR_LSB  = 7;
   // data, 32 bits
   localparam int DATA_LSB     = 39;
   // srcaddr, 32 bits, ends at PKT_W-1
   localparam int SRCADDR_LSB  = 71;

   // Transfer size of an emesh access
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_t;

endpackage

// File: hw/fifo_wr_ctrl.sv
//------------------
// Write-side FIFO controller: write pointer,
// read pointer sync, full and prog_full
//------------------
`timescale 1ns/1ps

module fifo_wr_ctrl (
   input  logic                        wr_clk,
   input  logic                        rst,
   input  logic                        wr_en,
   input  logic [emesh_pkg::PTR_W-1:0]  rd_gray,
   output logic [emesh_pkg::ADDR_W-1:0] wr_addr,
   output logic [emesh_pkg::PTR_W-1:0]  wr_gray,
   output logic                        wr_accept,
   output logic                        full,
   output logic                        prog_full
);

   import emesh_pkg::*;

   // Gray back to binary, MSB passes straight through
   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
      logic [PTR_W-1:0] b;
      b[PTR_W-1] = g[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   logic [PTR_W-1:0] rd_gray_s1;
   logic [PTR_W-1:0] rd_gray_s2;
   logic [PTR_W-1:0] rd_bin_sync;
   logic [PTR_W-1:0] wr_bin;
   logic [PTR_W-1:0] wr_bin_next;
   logic [PTR_W-1:0] level;

   // Two-flop synchronizer for the read pointer
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   assign rd_bin_sync = gray2bin(rd_gray_s2);

   // Fill level as seen from the write side, never underestimates
   assign level     = wr_bin - rd_bin_sync;
   assign full      = (level == PTR_W'(FIFO_DEPTH));
   assign prog_full = (level >= PTR_W'(PROG_FULL_LEVEL));

   // Writes under full are dropped here
   assign wr_accept   = wr_en & ~full;
   assign wr_bin_next = wr_bin + PTR_W'(wr_accept);

   // Gray copy registered from next value, same edge as the write
   always_ff @(posedge wr_clk) begin
      if (rst) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
      end
   end

   // Low bits address the memory
   assign wr_addr = wr_bin[ADDR_W-1:0];

endmodule

// File: hw/fifo_rd_ctrl.sv
//------------------
// Read-side FIFO controller: read pointer,
// write pointer sync and empty flag
//------------------
`timescale 1ns/1ps

module fifo_rd_ctrl (
   input  logic                        rd_clk,
   input  logic                        rst,
   input  logic                        rd_en,
   input  logic [emesh_pkg::PTR_W-1:0]  wr_gray,
   output logic [emesh_pkg::ADDR_W-1:0] rd_addr,
   output logic [emesh_pkg::PTR_W-1:0]  rd_gray,
   output logic                        empty
);

   import emesh_pkg::*;

   logic [PTR_W-1:0] wr_gray_s1;
   logic [PTR_W-1:0] wr_gray_s2;
   logic [PTR_W-1:0] rd_bin;
   logic [PTR_W-1:0] rd_bin_next;
   logic             rd_pop;

   // Two-flop synchronizer for the write pointer
   always_ff @(posedge rd_clk) begin
      if (rst) begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   // Gray codes match only when pointers are equal
   // Stale write pointer keeps this conservative
   assign empty = (rd_gray == wr_gray_s2);

   // Reads while empty are ignored
   assign rd_pop      = rd_en & ~empty;
   assign rd_bin_next = rd_bin + PTR_W'(rd_pop);

   // Pointer and its gray copy move together
   always_ff @(posedge rd_clk) begin
      if (rst) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
   end

   // Address of the oldest entry, used for fall-through read
   assign rd_addr = rd_bin[ADDR_W-1:0];

endmodule

// File: hw/fifo_async.sv
//------------------
// Dual-clock FIFO, 32 entries, with
// first-word-fall-through read
//------------------
`timescale 1ns/1ps

module fifo_async (
   input  logic                       wr_clk,
   input  logic                       rd_clk,
   input  logic                       rst,
   input  logic [emesh_pkg::PKT_W-1:0] din,
   input  logic                       wr_en,
   input  logic                       rd_en,
   output logic [emesh_pkg::PKT_W-1:0] dout,
   output logic                       full,
   output logic                       empty,
   output logic                       prog_full
);

   import emesh_pkg::*;

   // Packet storage
   logic [PKT_W-1:0] mem [FIFO_DEPTH];

   logic [ADDR_W-1:0] wr_addr;
   logic [ADDR_W-1:0] rd_addr;
   // Gray pointers crossing between domains
   logic [PTR_W-1:0]  wr_gray;
   logic [PTR_W-1:0]  rd_gray;
   logic              wr_accept;

   // Write domain
   fifo_wr_ctrl fifo_wr_ctrl_i (
      .wr_clk    (wr_clk),
      .rst       (rst),
      .wr_en     (wr_en),
      .rd_gray   (rd_gray),
      .wr_addr   (wr_addr),
      .wr_gray   (wr_gray),
      .wr_accept (wr_accept),
      .full      (full),
      .prog_full (prog_full)
   );

   // Read domain
   fifo_rd_ctrl fifo_rd_ctrl_i (
      .rd_clk  (rd_clk),
      .rst     (rst),
      .rd_en   (rd_en),
      .wr_gray (wr_gray),
      .rd_addr (rd_addr),
      .rd_gray (rd_gray),
      .empty   (empty)
   );

   // Memory write only on accepted packets
   always_ff @(posedge wr_clk) begin
      if (wr_accept) begin
         mem[wr_addr] <= din;
      end
   end

   // Head entry shown without a read cycle
   // Slot is stable until popped since writer cannot reach it
   assign dout = mem[rd_addr];

endmodule

// File: hw/fifo_async_emesh.sv
//------------------
// Emesh wrapper around the async FIFO,
// packs and unpacks the packet fields
//------------------
`timescale 1ns/1ps

module fifo_async_emesh (
   input  logic                 wr_clk,
   input  logic                 rd_clk,
   input  logic                 rst,
   input  logic                 emesh_access_in,
   input  logic                 emesh_write_in,
   input  emesh_pkg::datamode_t emesh_datamode_in,
   input  logic [3:0]           emesh_ctrlmode_in,
   input  logic [31:0]          emesh_dstaddr_in,
   input  logic [31:0]          emesh_data_in,
   input  logic [31:0]          emesh_srcaddr_in,
   input  logic                 fifo_read,
   output logic                 emesh_access_out,
   output logic                 emesh_write_out,
   output emesh_pkg::datamode_t emesh_datamode_out,
   output logic [3:0]           emesh_ctrlmode_out,
   output logic [31:0]          emesh_dstaddr_out,
   output logic [31:0]          emesh_data_out,
   output logic [31:0]          emesh_srcaddr_out,
   output logic                 fifo_full,
   output logic                 fifo_progfull
);

   import emesh_pkg::*;

   logic [PKT_W-1:0] fifo_din;
   logic [PKT_W-1:0] fifo_dout;
   logic             fifo_empty;

   // Pack fields, write bit lowest
   assign fifo_din[WRITE_POS]           = emesh_write_in;
   assign fifo_din[DATAMODE_LSB +: 2]   = emesh_datamode_in;
   assign fifo_din[CTRLMODE_LSB +: 4]   = emesh_ctrlmode_in;
   assign fifo_din[DSTADDR_LSB +: 32]   = emesh_dstaddr_in;
   assign fifo_din[DATA_LSB +: 32]      = emesh_data_in;
   assign fifo_din[SRCADDR_LSB +: 32]   = emesh_srcaddr_in;

   // Access is the write request, fifo_full acts as not-ready
   fifo_async fifo_async_i (
      .wr_clk    (wr_clk),
      .rd_clk    (rd_clk),
      .rst       (rst),
      .din       (fifo_din),
      .wr_en     (emesh_access_in),
      .rd_en     (fifo_read),
      .dout      (fifo_dout),
      .full      (fifo_full),
      .empty     (fifo_empty),
      .prog_full (fifo_progfull)
   );

   // Unpack head entry, valid whenever not empty
   assign emesh_access_out   = ~fifo_empty;
   assign emesh_write_out    = fifo_dout[WRITE_POS];
   assign emesh_datamode_out = datamode_t'(fifo_dout[DATAMODE_LSB +: 2]);
   assign emesh_ctrlmode_out = fifo_dout[CTRLMODE_LSB +: 4];
   assign emesh_dstaddr_out  = fifo_dout[DSTADDR_LSB +: 32];
   assign emesh_data_out     = fifo_dout[DATA_LSB +: 32];
   assign emesh_srcaddr_out  = fifo_dout[SRCADDR_LSB +: 32];

endmodule

// File: bench/emesh_checker.sv
//------------------
// Scoreboard and flag monitor
// for the emesh FIFO testbench
//------------------
`timescale 1ns/1ps

module emesh_checker (
   input  logic                 wr_clk,
   input  logic                 rd_clk,
   input  logic                 rst,
   input  logic                 emesh_access_in,
   input  logic                 emesh_write_in,
   input  emesh_pkg::datamode_t emesh_datamode_in,
   input  logic [3:0]           emesh_ctrlmode_in,
   input  logic [31:0]          emesh_dstaddr_in,
   input  logic [31:0]          emesh_data_in,
   input  logic [31:0]          emesh_srcaddr_in,
   input  logic                 fifo_read,
   input  logic                 emesh_access_out,
   input  logic                 emesh_write_out,
   input  emesh_pkg::datamode_t emesh_datamode_out,
   input  logic [3:0]           emesh_ctrlmode_out,
   input  logic [31:0]          emesh_dstaddr_out,
   input  logic [31:0]          emesh_data_out,
   input  logic [31:0]          emesh_srcaddr_out,
   input  logic                 fifo_full,
   input  logic                 fifo_progfull,
   output int                   checked,
   output int                   errors
);

   import emesh_pkg::*;

   // Accepted packets, oldest at the front
   logic [PKT_W-1:0] exp_q[$];
   logic [PKT_W-1:0] head;
   logic [PKT_W-1:0] seen;
   logic [PKT_W-1:0] held;
   logic             hold_valid;
   logic             wr_after_rst;
   logic             rd_after_rst;
   int               idle_edges;
   int               bad;
   int               wr_errors;
   int               rd_errors;

   assign errors = wr_errors + rd_errors;

   // Scoreboard layout: write, datamode, ctrlmode, dstaddr, data, srcaddr
   function automatic logic [PKT_W-1:0] pack_fields(input logic w, input logic [1:0] dm,
         input logic [3:0] cm, input logic [31:0] dst, input logic [31:0] data,
         input logic [31:0] src);
      return {w, dm, cm, dst, data, src};
   endfunction

   function automatic bit field_ok(input string name, input logic [31:0] exp,
         input logic [31:0] act);
      if (exp !== act) begin
         $display("FAIL %0t: %s expected %h, got %h", $time, name, exp, act);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   // Write domain: queue accepted packets, check flags against true fill
   always @(posedge wr_clk) begin
      if (rst) begin
         wr_after_rst = 1'b1;
         idle_edges   = 0;
      end else begin
         if (wr_after_rst && (fifo_full || fifo_progfull)) begin
            $display("FAIL %0t: fifo_full or fifo_progfull high after reset", $time);
            wr_errors++;
         end
         wr_after_rst = 1'b0;
         // Write-side level never undercounts, so these must hold
         if (exp_q.size() >= FIFO_DEPTH && !fifo_full) begin
            $display("FAIL %0t: fifo_full low with %0d packets queued", $time, exp_q.size());
            wr_errors++;
         end
         if (exp_q.size() >= PROG_FULL_LEVEL && !fifo_progfull) begin
            $display("FAIL %0t: fifo_progfull low with %0d packets queued", $time,
                     exp_q.size());
            wr_errors++;
         end
         // Pointer sync settles within 4 cycles of a drain
         if (exp_q.size() == 0 && !emesh_access_in) idle_edges++;
         else idle_edges = 0;
         if (idle_edges == 7 && (fifo_full || fifo_progfull)) begin
            $display("FAIL %0t: full flags still high after the FIFO drained", $time);
            wr_errors++;
         end
         if (emesh_access_in && !fifo_full) begin
            exp_q.push_back(pack_fields(emesh_write_in, emesh_datamode_in, emesh_ctrlmode_in,
                                        emesh_dstaddr_in, emesh_data_in, emesh_srcaddr_in));
         end
      end
   end

   // Read domain: compare pops, check stalled output stays put
   always @(posedge rd_clk) begin
      if (rst) begin
         rd_after_rst = 1'b1;
         hold_valid   = 1'b0;
         checked      = 0;
      end else begin
         if (rd_after_rst && emesh_access_out) begin
            $display("FAIL %0t: emesh_access_out high after reset", $time);
            rd_errors++;
         end
         rd_after_rst = 1'b0;
         seen = pack_fields(emesh_write_out, emesh_datamode_out, emesh_ctrlmode_out,
                            emesh_dstaddr_out, emesh_data_out, emesh_srcaddr_out);
         if (hold_valid && emesh_access_out && seen !== held) begin
            $display("FAIL %0t: output fields changed while fifo_read was low", $time);
            rd_errors++;
         end
         if (emesh_access_out && fifo_read) begin
            if (exp_q.size() == 0) begin
               $display("FAIL %0t: packet popped that was never accepted", $time);
               rd_errors++;
            end else begin
               head = exp_q.pop_front();
               bad  = 0;
               if (!field_ok("write", 32'(head[102]), 32'(seen[102]))) bad++;
               if (!field_ok("datamode", 32'(head[101:100]), 32'(seen[101:100]))) bad++;
               if (!field_ok("ctrlmode", 32'(head[99:96]), 32'(seen[99:96]))) bad++;
               if (!field_ok("dstaddr", head[95:64], seen[95:64])) bad++;
               if (!field_ok("data", head[63:32], seen[63:32])) bad++;
               if (!field_ok("srcaddr", head[31:0], seen[31:0])) bad++;
               if (bad == 0) checked++;
               else rd_errors += bad;
            end
            hold_valid = 1'b0;
         end else begin
            hold_valid = emesh_access_out;
            held       = seen;
         end
      end
   end

endmodule

// File: bench/fifo_async_emesh_tb.sv
//------------------
// Testbench for the emesh async FIFO
// Table-driven writes, throttled reads
//------------------
`timescale 1ns/1ps

module fifo_async_emesh_tb;

   import emesh_pkg::*;

   typedef enum logic [1:0] {RD_FREE, RD_STALL, RD_RANDOM} read_mode_t;

   // One test per row: count, base packet, read mode
   typedef struct packed {
      int          count;
      logic        wr;
      datamode_t   dm;
      logic [3:0]  cm;
      logic [31:0] dst;
      logic [31:0] data;
      logic [31:0] src;
      read_mode_t  mode;
   } row_t;

   localparam int NUM_ROWS = 4;

   logic wr_clk;
   logic rd_clk;
   logic rst;
   logic emesh_access_in;
   logic emesh_write_in;
   datamode_t emesh_datamode_in;
   logic [3:0] emesh_ctrlmode_in;
   logic [31:0] emesh_dstaddr_in;
   logic [31:0] emesh_data_in;
   logic [31:0] emesh_srcaddr_in;
   logic fifo_read;
   logic emesh_access_out;
   logic emesh_write_out;
   datamode_t emesh_datamode_out;
   logic [3:0] emesh_ctrlmode_out;
   logic [31:0] emesh_dstaddr_out;
   logic [31:0] emesh_data_out;
   logic [31:0] emesh_srcaddr_out;
   logic fifo_full;
   logic fifo_progfull;

   row_t rows [NUM_ROWS];
   logic [31:0] rng_state = 32'hb531_92b5;
   bit stall_release;
   int checked;
   int errors;
   int cycles = 0;
   int cycle_limit = 0;
   int failed_tests = 0;

   fifo_async_emesh fifo_async_emesh_i (.*);
   emesh_checker emesh_checker_i (.*);

   initial begin
      wr_clk = 1'b0;
      forever #10 wr_clk = ~wr_clk;
   end

   // Offset so read edges never meet write edges
   initial begin
      rd_clk = 1'b0;
      #7;
      forever #10 rd_clk = ~rd_clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Packet i of a row: base fields stepped by the index
   task automatic drive_packet(input int r, input int i);
      logic [1:0] dm_bits;
      dm_bits = rows[r].dm + i[1:0];
      emesh_access_in   <= 1'b1;
      emesh_write_in    <= rows[r].wr ^ i[0];
      emesh_datamode_in <= datamode_t'(dm_bits);
      emesh_ctrlmode_in <= rows[r].cm + i[3:0];
      emesh_dstaddr_in  <= rows[r].dst + 32'(i);
      emesh_data_in     <= rows[r].data ^ next_random(rows[r].data + 32'(i) + 32'd1);
      emesh_srcaddr_in  <= rows[r].src + 32'(i << 2);
   endtask

   task automatic send_row(input int r);
      int i;
      i = 0;
      while (i < rows[r].count) begin
         if (fifo_full) emesh_access_in <= 1'b0;
         else drive_packet(r, i);
         @(posedge wr_clk);
         if (emesh_access_in && !fifo_full) i++;
      end
      // FIFO is full now, this extra packet must be dropped
      if (rows[r].mode == RD_STALL) begin
         drive_packet(r, i);
         @(posedge wr_clk);
         stall_release = 1'b1;
      end
      emesh_access_in <= 1'b0;
   endtask

   task automatic read_row(input int r);
      int popped;
      popped = 0;
      while (popped < rows[r].count) begin
         @(posedge rd_clk);
         if (emesh_access_out && fifo_read) popped++;
         if (rows[r].mode == RD_RANDOM) rng_state = next_random(rng_state);
         if (popped >= rows[r].count) fifo_read <= 1'b0;
         else if (rows[r].mode == RD_FREE) fifo_read <= 1'b1;
         else if (rows[r].mode == RD_STALL) fifo_read <= stall_release;
         else fifo_read <= rng_state[0];
      end
   endtask

   always @(posedge wr_clk) begin
      cycles++;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d write clock cycles", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin : main
      int err_before;
      int chk_before;
      int total;
      rst = 1'b1;
      emesh_access_in = 1'b0;
      emesh_write_in = 1'b0;
      emesh_datamode_in = DM_BYTE;
      emesh_ctrlmode_in = 4'h0;
      emesh_dstaddr_in = 32'h0;
      emesh_data_in = 32'h0;
      emesh_srcaddr_in = 32'h0;
      fifo_read = 1'b0;
      stall_release = 1'b0;
      rows[0] = '{8, 1'b0, DM_BYTE, 4'h1, 32'h8000_0000, 32'h1234_5678, 32'h0000_1000, RD_FREE};
      rows[1] = '{32, 1'b1, DM_WORD, 4'h3, 32'h4000_0100, 32'hcafe_f00d, 32'h0002_0000, RD_STALL};
      rows[2] = '{64, 1'b0, DM_HALF, 4'h7, 32'h0000_8000, 32'h0bad_beef, 32'h00f0_0000, RD_RANDOM};
      rows[3] = '{12, 1'b1, DM_DOUBLE, 4'hc, 32'hffff_fff0, 32'h5a5a_a5a5, 32'h7fff_0000, RD_FREE};
      total = 0;
      for (int r = 0; r < NUM_ROWS; r++) total += rows[r].count;
      cycle_limit = total * 40 + 500;
      repeat (2) @(posedge wr_clk);
      rst <= 1'b0;
      @(posedge wr_clk);
      for (int r = 0; r < NUM_ROWS; r++) begin
         err_before = errors;
         chk_before = checked;
         stall_release = 1'b0;
         fork
            send_row(r);
            read_row(r);
         join
         // Wait for the drain to reach both domains
         while (emesh_access_out || fifo_full || fifo_progfull) @(posedge wr_clk);
         @(posedge wr_clk);
         if (errors == err_before && checked - chk_before == rows[r].count) begin
            $display("test %0d: %0d packets, %s reads, passed", r + 1, rows[r].count,
                     rows[r].mode.name());
         end else begin
            failed_tests++;
            $display("test %0d: %s reads, failed with %0d errors, %0d of %0d packets matched",
                     r + 1, rows[r].mode.name(), errors - err_before, checked - chk_before,
                     rows[r].count);
         end
      end
      $display("Done: %0d tests, %0d failed, %0d packets checked, %0d errors", NUM_ROWS,
               failed_tests, checked, errors);
      if (failed_tests == 0 && errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: fifo_async_emesh.f
hw/emesh_pkg.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_ctrl.sv
hw/fifo_async.sv
hw/fifo_async_emesh.sv
bench/emesh_checker.sv
bench/fifo_async_emesh_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module fifo_async_emesh_tb -f fifo_async_emesh.f -o sim

run: compile
	@out=$$(./obj_dir/sim); echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
